// File: common/dma_rd_pkg.sv
`default_nettype none

package dma_rd_pkg;

  //////////////////////////////////////////////////
  // sizes
  //////////////////////////////////////////////////
  localparam int num_ch         = 3;
  localparam int addr_w         = 32;
  localparam int data_w         = 64;
  localparam int id_w           = 4;
  localparam int link_depth_log = 1;
  localparam int pkt_depth_log  = 4;

  // fixed AR burst shape, three beats of 8 bytes
  localparam logic [7:0] burst_len  = 8'd2;
  localparam logic [2:0] beat_size  = 3'd3;
  localparam logic [1:0] burst_incr = 2'b01;

  // RRESP codes that carry good data
  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_exokay = 2'b01;

  //////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////
  typedef logic [addr_w-1:0] addr_t;
  typedef logic [data_w-1:0] data_t;
  typedef logic [id_w-1:0]   axi_id_t;
  typedef logic [7:0]        frag_cnt_t;
  typedef logic [7:0]        frag_code_t;
  // count in the upper byte, code in the lower byte
  typedef logic [15:0]       ctrl_word_t;
  typedef logic [num_ch-1:0] ch_mask_t;

  // fragment codes
  localparam frag_code_t frag_start = 8'h09;
  localparam frag_code_t frag_mid   = 8'h0b;
  localparam frag_code_t frag_end   = 8'h0d;

  typedef enum logic [1:0] {chan_free, chan_head, chan_link} chan_state_t;
  typedef enum logic {ar_idle, ar_wait} ar_state_t;

endpackage

`default_nettype wire

// File: files.f
common/dma_rd_pkg.sv
hdl/sync_fifo.sv
rd_addr/rr_arbiter.sv
rd_addr/ar_issue.sv
rd_chan/chan_ctrl.sv
rd_data/rdata_router.sv
hdl/dma_rd_top.sv
test/dma_rd_properties.sv
test/tb_dma_rd.sv

// File: hdl/dma_rd_top.sv
`timescale 1ns/1ps
`default_nettype none

module dma_rd_top (
  input  logic                                           clks,
  input  logic                                           rst_n,
  // descriptor queue
  input  logic                                           desc_empty,
  input  dma_rd_pkg::addr_t                              desc_addr,
  output logic                                           desc_pop,
  // AXI read address
  output logic                                           arvalid,
  output dma_rd_pkg::addr_t                              araddr,
  output dma_rd_pkg::axi_id_t                            arid,
  output logic [7:0]                                     arlen,
  output logic [2:0]                                     arsize,
  output logic [1:0]                                     arburst,
  input  logic                                           arready,
  // AXI read data
  input  logic                                           rvalid,
  input  dma_rd_pkg::data_t                              rdata,
  input  dma_rd_pkg::axi_id_t                            rid,
  input  logic [1:0]                                     rresp,
  input  logic                                           rlast,
  output logic                                           rready,
  // packet data per channel
  output dma_rd_pkg::data_t [dma_rd_pkg::num_ch-1:0]      pkt_data,
  output dma_rd_pkg::ch_mask_t                           pkt_empty,
  input  dma_rd_pkg::ch_mask_t                           pkt_pop,
  // packet control per channel
  output dma_rd_pkg::ctrl_word_t [dma_rd_pkg::num_ch-1:0] pkt_ctrl,
  output dma_rd_pkg::ch_mask_t                           pkt_ctrl_empty,
  input  dma_rd_pkg::ch_mask_t                           pkt_ctrl_pop
);
  import dma_rd_pkg::*;

  ch_mask_t               req;
  ch_mask_t               gnt;
  ch_mask_t               is_free;
  logic                   ar_fire;
  addr_t [num_ch-1:0]     next_addr;
  addr_t [num_ch-1:0]     head_addr;
  ch_mask_t               pkt_full;
  ch_mask_t               ctrl_full;
  ch_mask_t               pkt_push;
  ch_mask_t               ctrl_push;
  ch_mask_t               link_push;
  ch_mask_t               link_wrap;
  data_t                  pkt_din;
  ctrl_word_t             ctrl_din;
  addr_t                  link_data;

  //////////////////////////////////////////////////
  // read address side
  //////////////////////////////////////////////////
  rr_arbiter arb (
    .clks    (clks),
    .rst_n   (rst_n),
    .req     (req),
    .ar_fire (ar_fire),
    .gnt     (gnt)
  );

  ar_issue issue (
    .clks      (clks),
    .rst_n     (rst_n),
    .gnt       (gnt),
    .next_addr (next_addr),
    .is_free   (is_free),
    .arready   (arready),
    .arvalid   (arvalid),
    .araddr    (araddr),
    .arid      (arid),
    .arlen     (arlen),
    .arsize    (arsize),
    .arburst   (arburst),
    .ar_fire   (ar_fire),
    .desc_pop  (desc_pop)
  );

  //////////////////////////////////////////////////
  // read data side
  //////////////////////////////////////////////////
  rdata_router router (
    .clks      (clks),
    .rst_n     (rst_n),
    .rvalid    (rvalid),
    .rdata     (rdata),
    .rid       (rid),
    .rresp     (rresp),
    .rlast     (rlast),
    .head_addr (head_addr),
    .pkt_full  (pkt_full),
    .ctrl_full (ctrl_full),
    .rready    (rready),
    .pkt_push  (pkt_push),
    .pkt_din   (pkt_din),
    .ctrl_push (ctrl_push),
    .ctrl_din  (ctrl_din),
    .link_push (link_push),
    .link_wrap (link_wrap),
    .link_data (link_data)
  );

  // one controller and one FIFO pair per channel
  for (genvar i = 0; i < num_ch; i++) begin : g_ch
    chan_ctrl #(
      .ch_idx (i)
    ) chan (
      .clks       (clks),
      .rst_n      (rst_n),
      .desc_empty (desc_empty),
      .desc_addr  (desc_addr),
      .gnt_mine   (gnt[i]),
      .ar_fire    (ar_fire),
      .link_push  (link_push[i]),
      .link_wrap  (link_wrap[i]),
      .link_data  (link_data),
      .req        (req[i]),
      .is_free    (is_free[i]),
      .next_addr  (next_addr[i]),
      .head_addr  (head_addr[i])
    );

    sync_fifo #(
      .width     (data_w),
      .depth_log (pkt_depth_log)
    ) pkt_fifo (
      .clks  (clks),
      .rst_n (rst_n),
      .push  (pkt_push[i]),
      .pop   (pkt_pop[i]),
      .din   (pkt_din),
      .dout  (pkt_data[i]),
      .full  (pkt_full[i]),
      .empty (pkt_empty[i])
    );

    sync_fifo #(
      .width     ($bits(ctrl_word_t)),
      .depth_log (pkt_depth_log)
    ) ctrl_fifo (
      .clks  (clks),
      .rst_n (rst_n),
      .push  (ctrl_push[i]),
      .pop   (pkt_ctrl_pop[i]),
      .din   (ctrl_din),
      .dout  (pkt_ctrl[i]),
      .full  (ctrl_full[i]),
      .empty (pkt_ctrl_empty[i])
    );
  end

endmodule

`default_nettype wire

// File: hdl/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter int width     = 8,
  parameter int depth_log = 2
) (
  input  logic             clks,
  input  logic             rst_n,
  input  logic             push,
  input  logic             pop,
  input  logic [width-1:0] din,
  output logic [width-1:0] dout,
  output logic             full,
  output logic             empty
);

  logic [width-1:0] mem [2**depth_log];
  // one extra bit tells full from empty
  logic [depth_log:0] wptr;
  logic [depth_log:0] rptr;
  logic               do_push;
  logic               do_pop;

  assign do_push = push & ~full;
  assign do_pop  = pop & ~empty;

  assign empty = (wptr == rptr);
  assign full  = (wptr[depth_log] != rptr[depth_log]) &&
                 (wptr[depth_log-1:0] == rptr[depth_log-1:0]);

  // head word shows without a pop
  assign dout = mem[rptr[depth_log-1:0]];

  always_ff @(posedge clks) begin
    if (do_push) begin
      mem[wptr[depth_log-1:0]] <= din;
    end
  end

  always_ff @(posedge clks or negedge rst_n) begin
    if (!rst_n) begin
      wptr <= '0;
      rptr <= '0;
    end else begin
      if (do_push) begin
        wptr <= wptr + 1'b1;
      end
      if (do_pop) begin
        rptr <= rptr + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: rd_addr/ar_issue.sv
`timescale 1ns/1ps
`default_nettype none

module ar_issue (
  input  logic                                          clks,
  input  logic                                          rst_n,
  input  dma_rd_pkg::ch_mask_t                          gnt,
  input  dma_rd_pkg::addr_t [dma_rd_pkg::num_ch-1:0]    next_addr,
  input  dma_rd_pkg::ch_mask_t                          is_free,
  input  logic                                          arready,
  output logic                                          arvalid,
  output dma_rd_pkg::addr_t                             araddr,
  output dma_rd_pkg::axi_id_t                           arid,
  output logic [7:0]                                    arlen,
  output logic [2:0]                                    arsize,
  output logic [1:0]                                    arburst,
  output logic                                          ar_fire,
  output logic                                          desc_pop
);
  import dma_rd_pkg::*;

  ar_state_t state;
  axi_id_t   sel_id;
  addr_t     sel_addr;

  // index and address of the granted channel
  always_comb begin
    sel_id   = '0;
    sel_addr = next_addr[0];
    for (int i = 0; i < num_ch; i++) begin
      if (gnt[i]) begin
        sel_id   = axi_id_t'(i);
        sel_addr = next_addr[i];
      end
    end
  end

  //////////////////////////////////////////////////
  // address FSM
  //////////////////////////////////////////////////
  always_ff @(posedge clks or negedge rst_n) begin
    if (!rst_n) begin
      state <= ar_idle;
    end else begin
      case (state)
        ar_idle: if (gnt != '0) state <= ar_wait;
        ar_wait: if (arready) state <= ar_idle;
        default: state <= ar_idle;
      endcase
    end
  end

  // fields latched once, stable while arvalid waits
  always_ff @(posedge clks) begin
    if (state == ar_idle && gnt != '0) begin
      araddr <= sel_addr;
      arid   <= sel_id;
    end
  end

  assign arvalid = (state == ar_wait);
  assign ar_fire = arvalid & arready;

  assign arlen   = burst_len;
  assign arsize  = beat_size;
  assign arburst = burst_incr;

  // a free channel just took the queue head
  assign desc_pop = ar_fire & (|(gnt & is_free));

endmodule

`default_nettype wire

// File: rd_addr/rr_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter (
  input  logic                 clks,
  input  logic                 rst_n,
  input  dma_rd_pkg::ch_mask_t req,
  input  logic                 ar_fire,
  output dma_rd_pkg::ch_mask_t gnt
);
  import dma_rd_pkg::*;

  axi_id_t  last_id;
  axi_id_t  pick_id;
  ch_mask_t pick;

  // nearest requester after the last winner, wrapping around
  always_comb begin : pick_blk
    int cand;
    pick    = '0;
    pick_id = '0;
    cand    = 0;
    // walk from far to near so the nearest one sticks
    for (int off = num_ch; off >= 1; off--) begin
      cand = (int'(last_id) + off) % num_ch;
      if (req[cand]) begin
        pick       = '0;
        pick[cand] = 1'b1;
        pick_id    = axi_id_t'(cand);
      end
    end
  end

  // grant held until the address handshake
  always_ff @(posedge clks or negedge rst_n) begin
    if (!rst_n) begin
      gnt     <= '0;
      // channel 0 wins first
      last_id <= axi_id_t'(num_ch - 1);
    end else if (ar_fire) begin
      gnt <= '0;
    end else if (gnt == '0 && pick != '0) begin
      gnt     <= pick;
      last_id <= pick_id;
    end
  end

endmodule

`default_nettype wire

// File: rd_chan/chan_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module chan_ctrl #(
  parameter int ch_idx = 0
) (
  input  logic              clks,
  input  logic              rst_n,
  input  logic              desc_empty,
  input  dma_rd_pkg::addr_t desc_addr,
  input  logic              gnt_mine,
  input  logic              ar_fire,
  input  logic              link_push,
  input  logic              link_wrap,
  input  dma_rd_pkg::addr_t link_data,
  output logic              req,
  output logic              is_free,
  output dma_rd_pkg::addr_t next_addr,
  output dma_rd_pkg::addr_t head_addr
);
  import dma_rd_pkg::*;

  chan_state_t state;
  logic        own_fire;
  logic        link_pop;
  logic        link_empty;
  addr_t       link_head;

  if (ch_idx >= num_ch) begin : g_bad_idx
    $error("chan_ctrl ch_idx out of range");
  end

  assign own_fire = gnt_mine & ar_fire;
  assign is_free  = (state == chan_free);
  // link entry consumed by the burst it addresses
  assign link_pop = own_fire & ~is_free;

  // free channels ask for a descriptor, busy ones for the next link
  assign req       = is_free ? ~desc_empty : ~link_empty;
  assign next_addr = is_free ? desc_addr : link_head;

  //////////////////////////////////////////////////
  // channel FSM
  //////////////////////////////////////////////////
  always_ff @(posedge clks or negedge rst_n) begin
    if (!rst_n) begin
      state <= chan_free;
    end else begin
      case (state)
        chan_free: begin
          if (own_fire) state <= chan_head;
        end
        chan_head: begin
          if (link_wrap) begin
            state <= chan_free;
          end else if (link_push) begin
            state <= chan_link;
          end
        end
        chan_link: begin
          if (link_wrap) state <= chan_free;
        end
        default: state <= chan_free;
      endcase
    end
  end

  // ring head, compared against every link beat
  always_ff @(posedge clks) begin
    if (is_free && own_fire) begin
      head_addr <= desc_addr;
    end
  end

  // at most one link waits here, one burst in flight per channel
  sync_fifo #(
    .width     (addr_w),
    .depth_log (link_depth_log)
  ) link_fifo (
    .clks  (clks),
    .rst_n (rst_n),
    .push  (link_push),
    .pop   (link_pop),
    .din   (link_data),
    .dout  (link_head),
    .full  (),
    .empty (link_empty)
  );

endmodule

`default_nettype wire

// File: rd_data/rdata_router.sv
`timescale 1ns/1ps
`default_nettype none

module rdata_router (
  input  logic                                       clks,
  input  logic                                       rst_n,
  input  logic                                       rvalid,
  input  dma_rd_pkg::data_t                          rdata,
  input  dma_rd_pkg::axi_id_t                        rid,
  input  logic [1:0]                                 rresp,
  input  logic                                       rlast,
  input  dma_rd_pkg::addr_t [dma_rd_pkg::num_ch-1:0] head_addr,
  input  dma_rd_pkg::ch_mask_t                       pkt_full,
  input  dma_rd_pkg::ch_mask_t                       ctrl_full,
  output logic                                       rready,
  output dma_rd_pkg::ch_mask_t                       pkt_push,
  output dma_rd_pkg::data_t                          pkt_din,
  output dma_rd_pkg::ch_mask_t                       ctrl_push,
  output dma_rd_pkg::ctrl_word_t                     ctrl_din,
  output dma_rd_pkg::ch_mask_t                       link_push,
  output dma_rd_pkg::ch_mask_t                       link_wrap,
  output dma_rd_pkg::addr_t                          link_data
);
  import dma_rd_pkg::*;

  ch_mask_t  hit;
  ch_mask_t  in_ring;
  frag_cnt_t frag_cnt [num_ch];
  frag_cnt_t cnt_sel;
  addr_t     head_sel;
  logic      ring_sel;
  logic      resp_ok;
  logic      overflow;
  logic      beat_acc;
  logic      data_acc;
  logic      link_acc;
  logic      wrap;

  //////////////////////////////////////////////////
  // RID decode and per-channel selects
  //////////////////////////////////////////////////
  always_comb begin
    hit      = '0;
    cnt_sel  = '0;
    head_sel = head_addr[0];
    ring_sel = 1'b0;
    for (int i = 0; i < num_ch; i++) begin
      hit[i] = (rid == axi_id_t'(i));
      if (hit[i]) begin
        cnt_sel  = frag_cnt[i];
        head_sel = head_addr[i];
        ring_sel = in_ring[i];
      end
    end
  end

  // error beats are taken and dropped
  assign resp_ok = (rresp == resp_okay) || (rresp == resp_exokay);

  // data beats need room in pkt FIFO, link beats in ctrl FIFO
  assign overflow = resp_ok & (|(hit & (rlast ? ctrl_full : pkt_full)));
  assign rready   = rvalid & ~overflow;

  assign beat_acc = rvalid & rready & resp_ok;
  assign data_acc = beat_acc & ~rlast;
  assign link_acc = beat_acc & rlast;

  // link address back at the head closes the ring
  assign link_data = rdata[addr_w-1:0];
  assign wrap      = (link_data == head_sel);

  assign pkt_push  = data_acc ? hit : '0;
  assign ctrl_push = link_acc ? hit : '0;
  assign link_push = (link_acc & ~wrap) ? hit : '0;
  assign link_wrap = (link_acc & wrap) ? hit : '0;

  assign pkt_din  = rdata;
  assign ctrl_din = {cnt_sel, wrap ? frag_end : (ring_sel ? frag_mid : frag_start)};

  //////////////////////////////////////////////////
  // fragment counters and ring position
  //////////////////////////////////////////////////
  always_ff @(posedge clks or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < num_ch; i++) begin
        frag_cnt[i] <= '0;
      end
      in_ring <= '0;
    end else begin
      for (int i = 0; i < num_ch; i++) begin
        if (link_wrap[i]) begin
          frag_cnt[i] <= '0;
          in_ring[i]  <= 1'b0;
        end else begin
          if (pkt_push[i]) begin
            frag_cnt[i] <= frag_cnt[i] + 1'b1;
          end
          // past the first burst from here on
          if (link_push[i]) begin
            in_ring[i] <= 1'b1;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: test/dma_rd_properties.sv
`timescale 1ns/1ps
`default_nettype none

module dma_rd_properties (
  input  logic                 clks,
  input  logic                 rst_n,
  input  logic                 arvalid,
  input  logic                 arready,
  input  dma_rd_pkg::addr_t    araddr,
  input  dma_rd_pkg::axi_id_t  arid,
  input  logic                 desc_pop,
  input  dma_rd_pkg::addr_t    desc_addr,
  input  dma_rd_pkg::ch_mask_t pkt_push,
  input  dma_rd_pkg::ch_mask_t ctrl_push,
  input  dma_rd_pkg::ch_mask_t link_push
);
  import dma_rd_pkg::*;

  int fail_count = 0;

  // AR fields frozen while waiting for arready
  ar_stable: assert property (@(posedge clks) disable iff (!rst_n)
    arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arid))
    else begin
      fail_count++;
      $error("AR channel changed before arready");
    end

  // the popped queue entry is the address going out
  pop_with_ar: assert property (@(posedge clks) disable iff (!rst_n)
    desc_pop |-> arvalid && arready && (araddr == desc_addr))
    else begin
      fail_count++;
      $error("desc_pop without an AR handshake for the queue head");
    end

  quiet_in_reset: assert property (@(posedge clks)
    !rst_n |-> pkt_push == '0 && ctrl_push == '0 && link_push == '0)
    else begin
      fail_count++;
      $error("FIFO push during reset");
    end

endmodule

bind dma_rd_top dma_rd_properties props (
  .clks      (clks),
  .rst_n     (rst_n),
  .arvalid   (arvalid),
  .arready   (arready),
  .araddr    (araddr),
  .arid      (arid),
  .desc_pop  (desc_pop),
  .desc_addr (desc_addr),
  .pkt_push  (pkt_push),
  .ctrl_push (ctrl_push),
  .link_push (link_push)
);

`default_nettype wire

// File: test/tb_dma_rd.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dma_rd;
  import dma_rd_pkg::*;

  localparam int clk_period   = 40;
  localparam int drive_delay  = 2;
  localparam int n_fair       = 6;
  localparam int n_walk       = 18;
  localparam int n_bp         = 12;
  localparam int max_ring     = 4;
  localparam int mem_size     = 256;
  localparam int max_bursts   = (n_fair + n_walk + n_bp) * max_ring;
  // worst case per burst, with slack for random stalls
  localparam int burst_cycles = 60;
  localparam int stall_limit  = 400;
  localparam int watchdog_cycles = max_bursts * burst_cycles + stall_limit + 100;

  logic                              clks;
  logic                              rst_n;
  logic                              desc_empty;
  addr_t                             desc_addr;
  logic                              desc_pop;
  logic                              arvalid;
  addr_t                             araddr;
  axi_id_t                           arid;
  logic [7:0]                        arlen;
  logic [2:0]                        arsize;
  logic [1:0]                        arburst;
  logic                              arready;
  logic                              rvalid;
  data_t                             rdata;
  axi_id_t                           rid;
  logic [1:0]                        rresp;
  logic                              rlast;
  logic                              rready;
  data_t [num_ch-1:0]                pkt_data;
  ch_mask_t                          pkt_empty;
  ch_mask_t                          pkt_pop;
  ctrl_word_t [num_ch-1:0]           pkt_ctrl;
  ch_mask_t                          pkt_ctrl_empty;
  ch_mask_t                          pkt_ctrl_pop;

  // ring memory, burst serial number sits in address bits 23:8
  addr_t      burst_addr [mem_size];
  addr_t      burst_link [mem_size];
  logic       burst_last [mem_size];
  int         n_bursts;
  addr_t      desc_list [64];
  int         desc_wr;
  int         desc_rd;

  // model queues per channel, read and write counters
  addr_t      exp_addr [num_ch][mem_size];
  data_t      exp_data [num_ch][2*mem_size];
  ctrl_word_t exp_ctrl [num_ch][mem_size];
  int         ea_wr [num_ch];
  int         ea_rd [num_ch];
  int         ed_wr [num_ch];
  int         ed_rd [num_ch];
  int         ec_wr [num_ch];
  int         ec_rd [num_ch];
  logic       ring_open [num_ch];

  // slave side, bursts answered in AR order
  addr_t      pend_addr [mem_size];
  axi_id_t    pend_id [mem_size];
  int         pend_wr;
  int         pend_rd;
  int         beat;

  logic        s_ar_hs;
  logic        s_r_hs;
  logic        s_desc_pop;
  addr_t       s_araddr;
  axi_id_t     s_arid;
  logic [12:0] s_shape;

  logic [31:0] lfsr_state;
  logic        hold_pops;
  logic        stall_seen;
  int          ar_count;
  axi_id_t     first_ids [3];
  int          errors;
  int          tests_run;
  int          tests_failed;
  string       cur_test;

  dma_rd_top dma_rd_top_inst (
    .clks           (clks),
    .rst_n          (rst_n),
    .desc_empty     (desc_empty),
    .desc_addr      (desc_addr),
    .desc_pop       (desc_pop),
    .arvalid        (arvalid),
    .araddr         (araddr),
    .arid           (arid),
    .arlen          (arlen),
    .arsize         (arsize),
    .arburst        (arburst),
    .arready        (arready),
    .rvalid         (rvalid),
    .rdata          (rdata),
    .rid            (rid),
    .rresp          (rresp),
    .rlast          (rlast),
    .rready         (rready),
    .pkt_data       (pkt_data),
    .pkt_empty      (pkt_empty),
    .pkt_pop        (pkt_pop),
    .pkt_ctrl       (pkt_ctrl),
    .pkt_ctrl_empty (pkt_ctrl_empty),
    .pkt_ctrl_pop   (pkt_ctrl_pop)
  );

  initial begin : clock_gen
    clks = 1'b0;
    forever #(clk_period / 2) clks = ~clks;
  end

  //////////////////////////////////////////////////
  // random bits and reference values
  //////////////////////////////////////////////////
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  // what the slave memory holds for data beat k
  function automatic data_t beat_value(input addr_t a, input int k);
    return {a ^ 32'hc3a5_0f96, a + 32'(8 * k)};
  endfunction

  task automatic report_mismatch(input string what, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("** Error: test %s, %s expected %h, actual %h", cur_test, what, exp, act);
    errors++;
  endtask

  task automatic report_problem(input string msg);
    $display("Error: test %s, %s", cur_test, msg);
    errors++;
  endtask

  // new rings of min_len to max_ring bursts, heads into the queue
  task automatic load_rings(input int count, input int min_len);
    int          len;
    int          first;
    logic [31:0] r;
    for (int d = 0; d < count; d++) begin
      len = min_len + int'(take_bits(2));
      if (len > max_ring) len = max_ring;
      first = n_bursts;
      for (int j = 0; j < len; j++) begin
        r = take_bits(8);
        burst_addr[n_bursts] = {r[7:0], 16'(n_bursts), 8'h00};
        burst_last[n_bursts] = (j == len - 1);
        n_bursts++;
      end
      for (int j = 0; j < len; j++) begin
        burst_link[first + j] = burst_addr[first + (j + 1) % len];
      end
      desc_list[desc_wr] = burst_addr[first];
      desc_wr++;
    end
  endtask

  // whole ring predicted when a channel takes its descriptor
  task automatic expect_ring(input int ch, input addr_t head);
    int   s;
    int   j;
    logic last;
    s = int'(head[23:8]);
    j = 0;
    ring_open[ch] = 1'b1;
    do begin
      if (j > 0) begin
        exp_addr[ch][ea_wr[ch]] = burst_addr[s];
        ea_wr[ch]++;
      end
      exp_data[ch][ed_wr[ch]]     = beat_value(burst_addr[s], 0);
      exp_data[ch][ed_wr[ch] + 1] = beat_value(burst_addr[s], 1);
      ed_wr[ch] += 2;
      exp_ctrl[ch][ec_wr[ch]] = {8'(2 * (j + 1)),
                                 burst_last[s] ? 8'h0d : ((j == 0) ? 8'h09 : 8'h0b)};
      ec_wr[ch]++;
      last = burst_last[s];
      s = int'(burst_link[s][23:8]);
      j++;
    end while (!last);
  endtask

  //////////////////////////////////////////////////
  // AXI slave and FIFO consumer
  //////////////////////////////////////////////////
  task automatic track_address();
    int ch;
    ch = int'(s_arid);
    if (s_shape !== {8'd2, 3'd3, 2'b01}) begin
      report_mismatch("burst shape", {8'd2, 3'd3, 2'b01}, s_shape);
    end
    if (ar_count < 3) first_ids[ar_count] = s_arid;
    ar_count++;
    if (ch >= num_ch) begin
      report_problem($sformatf("arid %0d names no channel", ch));
    end else if (s_desc_pop) begin
      if (ring_open[ch]) begin
        report_problem($sformatf("channel %0d took a descriptor before its ring closed", ch));
      end
      if (s_araddr !== desc_list[desc_rd]) begin
        report_mismatch("descriptor address", desc_list[desc_rd], s_araddr);
      end
      expect_ring(ch, desc_list[desc_rd]);
      desc_rd++;
    end else if (ea_rd[ch] == ea_wr[ch]) begin
      report_problem($sformatf("channel %0d read past the end of its ring", ch));
    end else begin
      if (s_araddr !== exp_addr[ch][ea_rd[ch]]) begin
        report_mismatch($sformatf("channel %0d link address", ch),
                        exp_addr[ch][ea_rd[ch]], s_araddr);
      end
      ea_rd[ch]++;
    end
    pend_addr[pend_wr] = s_araddr;
    pend_id[pend_wr]   = s_arid;
    pend_wr++;
  endtask

  task automatic advance_slave();
    addr_t a;
    a = pend_addr[pend_rd];
    rvalid = 1'b0;
    if (beat == 2) begin
      if (burst_last[int'(a[23:8])] && pend_id[pend_rd] < num_ch) begin
        ring_open[pend_id[pend_rd]] = 1'b0;
      end
      pend_rd++;
      beat = 0;
    end else begin
      beat++;
    end
  endtask

  task automatic drive_slave();
    addr_t a;
    if (!rvalid && pend_rd < pend_wr && take_bits(2) != 0) begin
      a      = pend_addr[pend_rd];
      rvalid = 1'b1;
      rid    = pend_id[pend_rd];
      rlast  = (beat == 2);
      rresp  = take_bits(1) ? 2'b01 : 2'b00;
      rdata  = (beat == 2) ? {32'h0, burst_link[int'(a[23:8])]} : beat_value(a, beat);
    end
  endtask

  task automatic check_pops();
    for (int ch = 0; ch < num_ch; ch++) begin
      pkt_pop[ch]      = 1'b0;
      pkt_ctrl_pop[ch] = 1'b0;
      if (!hold_pops && !pkt_empty[ch] && take_bits(1)) begin
        if (ed_rd[ch] == ed_wr[ch]) begin
          report_problem($sformatf("channel %0d delivered an unexpected data beat", ch));
        end else begin
          if (pkt_data[ch] !== exp_data[ch][ed_rd[ch]]) begin
            report_mismatch($sformatf("channel %0d data", ch), exp_data[ch][ed_rd[ch]],
                            pkt_data[ch]);
          end
          ed_rd[ch]++;
        end
        pkt_pop[ch] = 1'b1;
      end
      if (!hold_pops && !pkt_ctrl_empty[ch] && take_bits(1)) begin
        if (ec_rd[ch] == ec_wr[ch]) begin
          report_problem($sformatf("channel %0d delivered an unexpected control word", ch));
        end else begin
          if (pkt_ctrl[ch] !== exp_ctrl[ch][ec_rd[ch]]) begin
            report_mismatch($sformatf("channel %0d control", ch), exp_ctrl[ch][ec_rd[ch]],
                            pkt_ctrl[ch]);
          end
          ec_rd[ch]++;
        end
        pkt_ctrl_pop[ch] = 1'b1;
      end
    end
  endtask

  // handshakes sampled mid cycle, inputs driven just after the edge
  initial begin : bus_loop
    @(posedge rst_n);
    forever begin
      @(negedge clks);
      s_ar_hs    = arvalid && arready;
      s_r_hs     = rvalid && rready;
      s_desc_pop = desc_pop;
      s_araddr   = araddr;
      s_arid     = arid;
      s_shape    = {arlen, arsize, arburst};
      if (rvalid && !rready) stall_seen = 1'b1;
      @(posedge clks);
      #(drive_delay);
      check_pops();
      if (s_r_hs) advance_slave();
      if (s_ar_hs) begin
        track_address();
      end else if (s_desc_pop) begin
        report_problem("desc_pop came without an address handshake");
      end
      drive_slave();
      arready    = (take_bits(2) != 0);
      desc_empty = (desc_rd >= desc_wr);
      desc_addr  = desc_empty ? '0 : desc_list[desc_rd];
    end
  end

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////
  function automatic logic all_drained();
    logic done;
    done = (desc_rd == desc_wr) && (pend_rd == pend_wr) && !rvalid;
    for (int c = 0; c < num_ch; c++) begin
      done = done && !ring_open[c] && (ed_rd[c] == ed_wr[c]) && (ec_rd[c] == ec_wr[c]) &&
             (ea_rd[c] == ea_wr[c]);
    end
    return done;
  endfunction

  task automatic run_until_drained();
    @(posedge clks);
    while (!all_drained()) begin
      @(posedge clks);
    end
  endtask

  task automatic finish_test(input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %s: passed", cur_test);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", cur_test, errors - errs_before);
    end
  endtask

  initial begin : main
    int errs;
    int cycles;
    rst_n = 1'b0;
    desc_empty = 1'b1;
    desc_addr = '0;
    arready = 1'b0;
    rvalid = 1'b0;
    rdata = '0;
    rid = '0;
    rresp = 2'b00;
    rlast = 1'b0;
    pkt_pop = '0;
    pkt_ctrl_pop = '0;
    lfsr_state = 32'd65818;
    n_bursts = 0;
    desc_wr = 0;
    desc_rd = 0;
    pend_wr = 0;
    pend_rd = 0;
    beat = 0;
    hold_pops = 1'b0;
    stall_seen = 1'b0;
    ar_count = 0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    for (int c = 0; c < num_ch; c++) begin
      ea_wr[c] = 0;
      ea_rd[c] = 0;
      ed_wr[c] = 0;
      ed_rd[c] = 0;
      ec_wr[c] = 0;
      ec_rd[c] = 0;
      ring_open[c] = 1'b0;
    end

    cur_test = "reset";
    errs = errors;
    repeat (8) @(posedge clks);
    #(drive_delay);
    rst_n = 1'b1;
    @(negedge clks);
    if (arvalid !== 1'b0) report_mismatch("arvalid", 0, arvalid);
    if (desc_pop !== 1'b0) report_mismatch("desc_pop", 0, desc_pop);
    if (rready !== 1'b0) report_mismatch("rready", 0, rready);
    if (pkt_empty !== {num_ch{1'b1}}) report_mismatch("pkt_empty", 3'b111, pkt_empty);
    if (pkt_ctrl_empty !== {num_ch{1'b1}}) begin
      report_mismatch("pkt_ctrl_empty", 3'b111, pkt_ctrl_empty);
    end
    finish_test(errs);

    // all channels free with a full queue
    cur_test = "fairness";
    errs = errors;
    #1;
    load_rings(n_fair, 1);
    while (ar_count < 3) @(posedge clks);
    for (int i = 0; i < 3; i++) begin
      if (first_ids[i] !== axi_id_t'(i)) begin
        report_mismatch($sformatf("arid of handshake %0d", i), i, first_ids[i]);
      end
    end
    run_until_drained();
    finish_test(errs);

    cur_test = "ring_walk";
    errs = errors;
    @(negedge clks);
    #1;
    load_rings(n_walk, 1);
    run_until_drained();
    finish_test(errs);

    // long rings with the consumer stopped
    cur_test = "back_pressure";
    errs = errors;
    @(negedge clks);
    #1;
    hold_pops = 1'b1;
    stall_seen = 1'b0;
    load_rings(n_bp, 3);
    cycles = 0;
    while (!stall_seen && cycles < stall_limit) begin
      @(posedge clks);
      cycles++;
    end
    if (!stall_seen) report_problem("rready never dropped while the packet FIFOs were full");
    hold_pops = 1'b0;
    run_until_drained();
    finish_test(errs);

    if (dma_rd_top_inst.props.fail_count != 0) begin
      $display("assertions failed %0d times", dma_rd_top_inst.props.fail_count);
      errors += dma_rd_top_inst.props.fail_count;
    end
    $display("tests run %0d, passed %0d, failed %0d, errors %0d", tests_run,
             tests_run - tests_failed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(watchdog_cycles * clk_period);
    $display("watchdog timeout, traffic did not finish in time");
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire
